/* eth_consts.svh */
`ifndef ETH_CONSTS_SVH
`define ETH_CONSTS_SVH

// --------------------
// packet rings
`define ETH_RING_DEPTH      4           // packets per ring
`define ETH_RING_W          2           // ring index bits
`define ETH_PACKET_SIZE     64          // max payload bytes
`define ETH_ADDR_W          16          // byte address and length

// --------------------
// framing
`define ETH_PREAMBLE_BYTE   8'h55
`define ETH_PREAMBLE_COUNT  7
`define ETH_SFD_BYTE        8'hD5
`define ETH_FCS_BYTES       4
`define ETH_IFG_CYCLES      12          // idle cycles between frames

// crc-32 register values, reflected form
`define ETH_CRC_INIT        32'hFFFFFFFF
`define ETH_CRC_RESIDUE     32'hDEBB20E3

`endif

/* eth_host_pkg.sv */
`default_nettype none

`include "eth_consts.svh"

package eth_host_pkg;

	// --------------------
	// host command set
	typedef enum logic [3:0] {
		OP_READ       = 4'd0,   // byte of the oldest received packet
		OP_READ_LEN   = 4'd1,   // its length
		OP_READ_NEXT  = 4'd2,   // release it
		OP_WRITE      = 4'd3,   // byte into the packet being built
		OP_WRITE_LEN  = 4'd4,   // build length so far
		OP_WRITE_NEXT = 4'd5    // queue it for sending
	} host_op_t;

	// --------------------
	// host data
	typedef logic [`ETH_ADDR_W-1:0] host_addr_t;   // byte address or length

	// Reply word. Bytes, lengths and status flags are all zero extended
	// into this width.
	typedef logic [15:0] host_reply_t;

endpackage

`default_nettype wire

/* eth_frame_pkg.sv */
`default_nettype none

package eth_frame_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [31:0] crc_t;

	// --------------------
	// transmit FSM
	typedef enum logic [2:0] {
		TX_IDLE,        // waiting for a queued packet
		TX_PREAMBLE,
		TX_SFD,
		TX_DATA,
		TX_FCS,
		TX_GAP          // inter frame gap, slot still held
	} tx_state_t;

	// --------------------
	// receive FSM
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_PREAMBLE,    // counting 0x55 bytes, then the SFD
		RX_DATA,        // payload and FCS
		RX_DROP         // bad frame, wait for rx_dv low
	} rx_state_t;

	// One byte of IEEE 802.3 CRC-32 in reflected form. Bits go in LSB
	// first, so the register shifts right against the reversed polynomial.
	function automatic crc_t crc32_step(input byte_t data, input crc_t crc);
		crc_t c;
		c = crc ^ {24'h000000, data};
		for (int i = 0; i < 8; i++) begin
			if (c[0]) begin
				c = (c >> 1) ^ 32'hEDB88320;   // reversed 0x04C11DB7
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

endpackage

`default_nettype wire

/* eth_tx_path.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_consts.svh"

module eth_tx_path import eth_frame_pkg::*; (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic                   wr_strobe,
	input  wire logic [`ETH_ADDR_W-1:0] wr_address,
	input  wire byte_t                  wr_value,
	input  wire logic                   commit_strobe,
	output logic                        wr_status,
	output logic                        commit_status,
	output logic [`ETH_ADDR_W-1:0]      build_len,
	output byte_t                       tx_data,
	output logic                        tx_en,
	output logic                        tx_er
);

	localparam int BYTE_W = $clog2(`ETH_PACKET_SIZE);

	byte_t                  tx_mem [`ETH_RING_DEPTH][`ETH_PACKET_SIZE];
	logic [`ETH_ADDR_W-1:0] tx_len [`ETH_RING_DEPTH];

	logic [`ETH_RING_W:0]   wr_ptr;     // extra bit tells full from empty
	logic [`ETH_RING_W:0]   send_ptr;
	logic [`ETH_RING_W-1:0] wr_idx;
	logic [`ETH_RING_W-1:0] send_idx;
	logic                   ring_full;
	logic                   ring_empty;

	tx_state_t              state;
	logic [`ETH_ADDR_W-1:0] count;      // byte or cycle count within a state
	logic [`ETH_ADDR_W-1:0] send_len;
	crc_t                   crc;
	crc_t                   fcs;
	byte_t                  mem_byte;
	byte_t                  frame_byte;
	logic                   frame_en;

	assign wr_idx     = wr_ptr[`ETH_RING_W-1:0];
	assign send_idx   = send_ptr[`ETH_RING_W-1:0];
	assign ring_empty = (wr_ptr == send_ptr);
	assign ring_full  = (wr_idx == send_idx) && (wr_ptr[`ETH_RING_W] != send_ptr[`ETH_RING_W]);

	// when full the build slot is the one on the wire, so writes are refused too
	assign wr_status     = (wr_address >= `ETH_PACKET_SIZE) || ring_full;
	assign commit_status = ring_full;

	// --------------------
	// host side of the ring
	always_ff @(posedge clock) begin
		if (wr_strobe && !wr_status) begin
			tx_mem[wr_idx][wr_address[BYTE_W-1:0]] <= wr_value;
		end
		if (commit_strobe && !ring_full) begin
			tx_len[wr_idx] <= build_len;   // length frozen at commit
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr    <= '0;
			build_len <= '0;
		end else begin
			if (wr_strobe && !wr_status && (wr_address >= build_len)) begin
				build_len <= wr_address + 1'b1;
			end
			if (commit_strobe && !ring_full) begin
				wr_ptr    <= wr_ptr + 1'b1;
				build_len <= '0;           // fresh empty packet
			end
		end
	end

	// --------------------
	// frame sender
	assign send_len = tx_len[send_idx];
	assign mem_byte = tx_mem[send_idx][count[BYTE_W-1:0]];
	assign fcs      = ~crc;

	always_comb begin
		frame_en   = 1'b1;
		frame_byte = `ETH_PREAMBLE_BYTE;
		case (state)
			TX_PREAMBLE: frame_byte = `ETH_PREAMBLE_BYTE;
			TX_SFD:      frame_byte = `ETH_SFD_BYTE;
			TX_DATA:     frame_byte = mem_byte;
			TX_FCS:      frame_byte = fcs[8*count[1:0] +: 8];   // low byte first
			default: begin
				frame_en   = 1'b0;
				frame_byte = 8'h00;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= TX_IDLE;
			send_ptr <= '0;
			count    <= '0;
			tx_en    <= 1'b0;
		end else begin
			tx_en <= frame_en;
			case (state)
				TX_IDLE: begin
					count <= '0;
					if (!ring_empty) begin
						state <= TX_PREAMBLE;
					end
				end
				TX_PREAMBLE: begin
					if (count == `ETH_PREAMBLE_COUNT - 1) begin
						state <= TX_SFD;
					end else begin
						count <= count + 1'b1;
					end
				end
				TX_SFD: begin
					count <= '0;
					state <= (send_len == '0) ? TX_FCS : TX_DATA;
				end
				TX_DATA: begin
					if (count == send_len - 1'b1) begin
						count <= '0;
						state <= TX_FCS;
					end else begin
						count <= count + 1'b1;
					end
				end
				TX_FCS: begin
					if (count == `ETH_FCS_BYTES - 1) begin
						count <= '0;
						state <= TX_GAP;
					end else begin
						count <= count + 1'b1;
					end
				end
				TX_GAP: begin
					if (count == `ETH_IFG_CYCLES - 1) begin
						send_ptr <= send_ptr + 1'b1;   // slot freed after the gap
						state    <= TX_IDLE;
					end else begin
						count <= count + 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		tx_data <= frame_byte;
		if (state == TX_SFD) begin
			crc <= `ETH_CRC_INIT;
		end else if (state == TX_DATA) begin
			crc <= crc32_step(mem_byte, crc);
		end
	end

	assign tx_er = 1'b0;   // never signals an error

endmodule

`default_nettype wire

/* eth_rx_path.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_consts.svh"

module eth_rx_path import eth_frame_pkg::*; (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire byte_t                  rx_data,
	input  wire logic                   rx_dv,
	input  wire logic                   rx_er,
	input  wire logic                   rd_release_strobe,
	input  wire logic [`ETH_ADDR_W-1:0] rd_address,
	output byte_t                       rd_byte,
	output logic [`ETH_ADDR_W-1:0]      rd_len,
	output logic                        rd_empty
);

	localparam int BYTE_W = $clog2(`ETH_PACKET_SIZE);

	byte_t                  rx_mem [`ETH_RING_DEPTH][`ETH_PACKET_SIZE];
	logic [`ETH_ADDR_W-1:0] rx_len [`ETH_RING_DEPTH];

	logic [`ETH_RING_W:0]   wr_ptr;
	logic [`ETH_RING_W:0]   rd_ptr;
	logic [`ETH_RING_W-1:0] wr_idx;
	logic [`ETH_RING_W-1:0] rd_idx;
	logic                   ring_full;

	rx_state_t              state;
	logic [`ETH_ADDR_W-1:0] count;      // preamble bytes, then frame bytes
	crc_t                   crc;
	logic                   store_byte;
	logic                   frame_ok;

	assign wr_idx    = wr_ptr[`ETH_RING_W-1:0];
	assign rd_idx    = rd_ptr[`ETH_RING_W-1:0];
	assign rd_empty  = (wr_ptr == rd_ptr);
	assign ring_full = (wr_idx == rd_idx) && (wr_ptr[`ETH_RING_W] != rd_ptr[`ETH_RING_W]);

	// FCS bytes past the payload area are only fed to the CRC
	assign store_byte = (state == RX_DATA) && rx_dv && !rx_er && (count < `ETH_PACKET_SIZE);

	// Frame end. Running the CRC over payload and FCS leaves the fixed
	// residue when nothing was corrupted.
	assign frame_ok = (state == RX_DATA) && !rx_dv && (crc == `ETH_CRC_RESIDUE)
		&& (count >= `ETH_FCS_BYTES);

	// --------------------
	// receive ring storage
	always_ff @(posedge clock) begin
		if (store_byte) begin
			rx_mem[wr_idx][count[BYTE_W-1:0]] <= rx_data;
		end
		if (frame_ok) begin
			rx_len[wr_idx] <= count - `ETH_FCS_BYTES;   // FCS not counted
		end
	end

	// --------------------
	// frame receiver
	always_ff @(posedge clock) begin
		if (reset) begin
			state  <= RX_IDLE;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (rd_release_strobe) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case (state)
				RX_IDLE: begin
					count <= '0;
					if (rx_dv) begin
						if (rx_er || (rx_data != `ETH_PREAMBLE_BYTE)) begin
							state <= RX_DROP;
						end else begin
							count <= 1;
							state <= RX_PREAMBLE;
						end
					end
				end
				RX_PREAMBLE: begin
					if (!rx_dv) begin
						state <= RX_IDLE;            // cut short, nothing kept
					end else if (rx_er) begin
						state <= RX_DROP;
					end else if (count < `ETH_PREAMBLE_COUNT) begin
						if (rx_data == `ETH_PREAMBLE_BYTE) begin
							count <= count + 1'b1;
						end else begin
							state <= RX_DROP;
						end
					end else if ((rx_data == `ETH_SFD_BYTE) && !ring_full) begin
						count <= '0;
						state <= RX_DATA;
					end else begin
						state <= RX_DROP;            // bad SFD or no free slot
					end
				end
				RX_DATA: begin
					if (!rx_dv) begin
						if (frame_ok) begin
							wr_ptr <= wr_ptr + 1'b1;
						end
						state <= RX_IDLE;
					end else if (rx_er || (count == `ETH_PACKET_SIZE + `ETH_FCS_BYTES)) begin
						state <= RX_DROP;
					end else begin
						count <= count + 1'b1;
					end
				end
				RX_DROP: begin
					if (!rx_dv) begin
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == RX_PREAMBLE) begin
			crc <= `ETH_CRC_INIT;
		end else if ((state == RX_DATA) && rx_dv) begin
			crc <= crc32_step(rx_data, crc);
		end
	end

	// --------------------
	// host read side
	assign rd_len  = rd_empty ? '0 : rx_len[rd_idx];
	assign rd_byte = (rd_address < rd_len) ? rx_mem[rd_idx][rd_address[BYTE_W-1:0]] : 8'h00;

endmodule

`default_nettype wire

/* eth_host_port.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_host_port import eth_host_pkg::*, eth_frame_pkg::*; (
	input  wire logic       clock,
	input  wire logic       reset,
	input  wire logic       start,
	input  wire host_op_t   op,
	input  wire host_addr_t address,
	input  wire byte_t      value,
	output logic            done,
	output host_reply_t     reply,
	output logic            wr_strobe,
	output host_addr_t      wr_address,
	output byte_t           wr_value,
	output logic            commit_strobe,
	output logic            rd_release_strobe,
	output host_addr_t      rd_address,
	input  wire logic       wr_status,
	input  wire logic       commit_status,
	input  wire host_addr_t build_len,
	input  wire byte_t      rd_byte,
	input  wire host_addr_t rd_len,
	input  wire logic       rd_empty
);

	host_reply_t reply_next;

	// --------------------
	// command steering
	assign wr_strobe         = start && (op == OP_WRITE);
	assign commit_strobe     = start && (op == OP_WRITE_NEXT);
	assign rd_release_strobe = start && (op == OP_READ_NEXT) && !rd_empty;   // empty ring untouched
	assign wr_address        = address;
	assign wr_value          = value;
	assign rd_address        = address;

	// both paths answer in the start cycle
	always_comb begin
		case (op)
			OP_READ:       reply_next = host_reply_t'(rd_byte);
			OP_READ_LEN:   reply_next = host_reply_t'(rd_len);
			OP_READ_NEXT:  reply_next = host_reply_t'(rd_empty);   // 1 means nothing to release
			OP_WRITE:      reply_next = host_reply_t'(wr_status);
			OP_WRITE_LEN:  reply_next = host_reply_t'(build_len);
			OP_WRITE_NEXT: reply_next = host_reply_t'(commit_status);
			default:       reply_next = '0;
		endcase
	end

	// --------------------
	// reply register
	always_ff @(posedge clock) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= start;   // one cycle after start
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			reply <= reply_next;
		end
	end

endmodule

`default_nettype wire

/* eth_mac_top.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_mac_top import eth_host_pkg::*, eth_frame_pkg::*; (
	input  wire logic       clock,
	input  wire logic       reset,
	input  wire logic       start,
	input  wire host_op_t   op,
	input  wire host_addr_t address,
	input  wire byte_t      value,
	output logic            done,
	output host_reply_t     reply,
	output byte_t           tx_data,
	output logic            tx_en,
	output logic            tx_er,
	input  wire byte_t      rx_data,
	input  wire logic       rx_dv,
	input  wire logic       rx_er
);

	// host port to transmit path
	logic       wr_strobe;
	host_addr_t wr_address;
	byte_t      wr_value;
	logic       commit_strobe;
	logic       wr_status;
	logic       commit_status;
	host_addr_t build_len;

	// host port to receive path
	logic       rd_release_strobe;
	host_addr_t rd_address;
	byte_t      rd_byte;
	host_addr_t rd_len;
	logic       rd_empty;

	eth_host_port u_host (
		.clock, .reset, .start, .op, .address, .value, .done, .reply,
		.wr_strobe, .wr_address, .wr_value, .commit_strobe,
		.rd_release_strobe, .rd_address,
		.wr_status, .commit_status, .build_len,
		.rd_byte, .rd_len, .rd_empty
	);

	eth_tx_path u_tx (
		.clock, .reset, .wr_strobe, .wr_address, .wr_value, .commit_strobe,
		.wr_status, .commit_status, .build_len,
		.tx_data, .tx_en, .tx_er
	);

	eth_rx_path u_rx (
		.clock, .reset, .rx_data, .rx_dv, .rx_er,
		.rd_release_strobe, .rd_address,
		.rd_byte, .rd_len, .rd_empty
	);

endmodule

`default_nettype wire

/* tb_eth_mac.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_consts.svh"

module tb_eth_mac import eth_host_pkg::*, eth_frame_pkg::*;;

	logic        clock;
	logic        reset;
	logic        start;
	host_op_t    op;
	host_addr_t  address;
	byte_t       value;
	logic        done;
	host_reply_t reply;
	byte_t       tx_data;
	logic        tx_en;
	logic        tx_er;
	byte_t       rx_data;
	logic        rx_dv;
	logic        rx_er;

	byte_t       drv_data;          // rx stimulus from the tasks
	logic        drv_dv;
	logic        drv_er;
	byte_t       lb_data;           // tx outputs, copied just after each edge
	logic        lb_dv;
	logic        lb_er;
	logic        loopback;

	int          errors;
	int          mon_errors;        // counted by the tx monitor
	int          tests_run;
	int          tests_failed;
	int          test_base;
	logic [31:0] lfsr;
	logic [31:0] rnd;
	host_reply_t r;
	byte_t       pkt_a [`ETH_PACKET_SIZE];
	byte_t       pkt_b [`ETH_PACKET_SIZE];
	int          len_a;
	int          len_b;

	byte_t       cap_bytes [$];     // captured frames, back to back
	int          cap_lens [$];
	int          cap_pos;
	int          frames_taken;
	int          cur_len;
	int          idle_cycles;

	assign rx_data = loopback ? lb_data : drv_data;
	assign rx_dv   = loopback ? lb_dv : drv_dv;
	assign rx_er   = loopback ? lb_er : drv_er;

	eth_mac_top dut0 (
		.clock, .reset, .start, .op, .address, .value, .done, .reply,
		.tx_data, .tx_en, .tx_er, .rx_data, .rx_dv, .rx_er
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		#1;
		lb_data = tx_data;
		lb_dv   = tx_en;
		lb_er   = tx_er;
	end

	// --------------------
	// tx frame monitor
	always @(negedge clock) begin
		if (reset === 1'b0) begin
			if (tx_er !== 1'b0) begin
				mon_errors++;
				$display("mismatch at %0t: tx_er is not low", $time);
			end
			if (tx_en === 1'b1) begin
				if ((cur_len == 0) && (cap_lens.size() > 0) && (idle_cycles < `ETH_IFG_CYCLES)) begin
					mon_errors++;
					$display("mismatch at %0t: only %0d idle cycles between frames", $time,
						idle_cycles);
				end
				cap_bytes.push_back(tx_data);
				cur_len++;
				idle_cycles = 0;
			end else begin
				if (cur_len > 0) begin
					cap_lens.push_back(cur_len);   // frame just ended
					cur_len = 0;
				end
				idle_cycles++;
			end
		end
	end

	// --------------------
	// helpers
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);   // one step per bit
		end
	endtask

	task automatic random_payload(input int n, output byte_t data [`ETH_PACKET_SIZE]);
		logic [31:0] v;
		for (int i = 0; i < `ETH_PACKET_SIZE; i++) begin
			data[i] = 8'h00;
			if (i < n) begin
				take_bits(8, v);
				data[i] = v[7:0];
			end
		end
	endtask

	// bit serial crc-32, result already complemented
	function automatic logic [31:0] ref_crc(input byte_t data [`ETH_PACKET_SIZE], input int n);
		logic [31:0] c;
		logic        fb;
		c = 32'hFFFFFFFF;
		for (int i = 0; i < n; i++) begin
			for (int b = 0; b < 8; b++) begin
				fb = c[0] ^ data[i][b];
				c  = {1'b0, c[31:1]};
				if (fb) begin
					c = c ^ 32'hEDB88320;
				end
			end
		end
		return ~c;
	endfunction

	function automatic byte_t frame_byte_at(input byte_t data [`ETH_PACKET_SIZE], input int n,
		input logic [31:0] fcs, input int i);
		if (i < 7) begin
			return 8'h55;
		end else if (i == 7) begin
			return 8'hD5;
		end else if (i < 8 + n) begin
			return data[i - 8];
		end
		return fcs[8 * (i - 8 - n) +: 8];   // fcs low byte first
	endfunction

	task automatic report_mismatch(input string what, input int got, input int want);
		errors++;
		$display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, want);
	endtask

	task automatic host_cmd(input host_op_t cmd, input host_addr_t addr, input byte_t val,
		output host_reply_t res);
		int t;
		@(posedge clock);
		#1;
		start   = 1'b1;
		op      = cmd;
		address = addr;
		value   = val;
		@(posedge clock);
		#1;
		start = 1'b0;
		t     = 1;
		while (!done && (t < 20)) begin
			@(posedge clock);
			#1;
			t++;
		end
		res = reply;
		if (!done) begin
			errors++;
			res = '0;
			$display("no done for host command %s before the timeout", cmd.name());
		end else if (t != 1) begin
			report_mismatch("done latency", t, 1);
		end
	endtask

	task automatic end_test(input string name);
		int now;
		now = errors + mon_errors;
		tests_run++;
		if (now == test_base) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, now - test_base);
		end
		test_base = now;
	endtask

	// --------------------
	// tx side
	task automatic send_packet(input byte_t data [`ETH_PACKET_SIZE], input int n);
		host_reply_t res;
		for (int i = 0; i < n; i++) begin
			host_cmd(OP_WRITE, host_addr_t'(i), data[i], res);
			if (res != 16'd0) begin
				report_mismatch("write status", int'(res), 0);
			end
		end
		host_cmd(OP_WRITE_LEN, '0, '0, res);
		if (res != host_reply_t'(n)) begin
			report_mismatch("build length", int'(res), n);
		end
		host_cmd(OP_WRITE_NEXT, '0, '0, res);
		if (res != 16'd0) begin
			report_mismatch("commit status", int'(res), 0);
		end
	endtask

	task automatic check_tx_frame(input byte_t data [`ETH_PACKET_SIZE], input int n,
		input string tag);
		int          t;
		int          len;
		logic [31:0] fcs;
		byte_t       want;
		t = 0;
		while ((cap_lens.size() <= frames_taken) && (t < 4000)) begin
			@(posedge clock);
			#1;
			t++;
		end
		if (cap_lens.size() <= frames_taken) begin
			errors++;
			$display("no %s frame appeared on tx_en before the timeout", tag);
		end else begin
			fcs = ref_crc(data, n);
			len = cap_lens[frames_taken];
			if (len != 12 + n) begin
				report_mismatch({tag, " frame length"}, len, 12 + n);
			end else begin
				for (int i = 0; i < len; i++) begin
					want = frame_byte_at(data, n, fcs, i);
					if (cap_bytes[cap_pos + i] != want) begin
						report_mismatch($sformatf("%s frame byte %0d", tag, i),
							int'(cap_bytes[cap_pos + i]), int'(want));
					end
				end
			end
			cap_pos += len;
			frames_taken++;
		end
	endtask

	task automatic wait_tx_idle();
		int t;
		t = 0;
		while ((idle_cycles < `ETH_IFG_CYCLES + 2) && (t < 2000)) begin
			@(posedge clock);
			#1;
			t++;
		end
		if (idle_cycles < `ETH_IFG_CYCLES + 2) begin
			errors++;
			$display("transmit path did not go idle before the timeout");
		end
	endtask

	// --------------------
	// rx side
	// fault 1 corrupts an fcs byte, 2 breaks the preamble, 3 raises rx_er
	task automatic drive_rx(input byte_t data [`ETH_PACKET_SIZE], input int n, input int fault);
		logic [31:0] fcs;
		fcs = ref_crc(data, n);
		if (fault == 1) begin
			fcs[15:8] = fcs[15:8] ^ 8'h20;
		end
		for (int i = 0; i < 12 + n; i++) begin
			@(posedge clock);
			#1;
			drv_dv   = 1'b1;
			drv_er   = (fault == 3) && (i == 10);
			drv_data = frame_byte_at(data, n, fcs, i);
			if ((fault == 2) && (i == 3)) begin
				drv_data = 8'h5D;
			end
		end
		@(posedge clock);
		#1;
		drv_dv   = 1'b0;
		drv_er   = 1'b0;
		drv_data = 8'h00;
	endtask

	task automatic check_rx_packet(input byte_t data [`ETH_PACKET_SIZE], input int n,
		input string tag);
		host_reply_t res;
		int          t;
		res = '0;
		t   = 0;
		while ((res == 16'd0) && (t < 100)) begin
			host_cmd(OP_READ_LEN, '0, '0, res);   // 0 while nothing stored
			t++;
		end
		if (res == 16'd0) begin
			errors++;
			$display("%s packet did not become readable before the timeout", tag);
		end else begin
			if (res != host_reply_t'(n)) begin
				report_mismatch({tag, " length"}, int'(res), n);
			end
			for (int i = 0; i < n; i++) begin
				host_cmd(OP_READ, host_addr_t'(i), '0, res);
				if (res != {8'h00, data[i]}) begin
					report_mismatch($sformatf("%s byte %0d", tag, i), int'(res), int'(data[i]));
				end
			end
			host_cmd(OP_READ, host_addr_t'(n), '0, res);
			if (res != 16'd0) begin
				report_mismatch({tag, " read past length"}, int'(res), 0);
			end
			host_cmd(OP_READ_NEXT, '0, '0, res);
			if (res != 16'd0) begin
				report_mismatch({tag, " release"}, int'(res), 0);
			end
		end
	endtask

	// --------------------
	// directed tests
	initial begin
		reset    = 1'b1;
		start    = 1'b0;
		op       = OP_READ;
		address  = '0;
		value    = '0;
		drv_data = '0;
		drv_dv   = 1'b0;
		drv_er   = 1'b0;
		loopback = 1'b0;
		lfsr     = 32'h4daf;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;

		if (tx_en !== 1'b0) begin
			report_mismatch("tx_en after reset", int'(tx_en), 0);
		end
		host_cmd(OP_READ_NEXT, '0, '0, r);
		if (r != 16'd1) begin
			report_mismatch("empty rx ring", int'(r), 1);
		end
		host_cmd(OP_READ_LEN, '0, '0, r);
		if (r != 16'd0) begin
			report_mismatch("rx length after reset", int'(r), 0);
		end
		host_cmd(OP_WRITE_LEN, '0, '0, r);
		if (r != 16'd0) begin
			report_mismatch("build length after reset", int'(r), 0);
		end
		end_test("reset state");

		random_payload(10, pkt_a);
		for (int i = 0; i < 10; i++) begin
			host_cmd(OP_WRITE, host_addr_t'(i), pkt_a[i], r);
			if (r != 16'd0) begin
				report_mismatch("write status", int'(r), 0);
			end
		end
		take_bits(8, rnd);
		pkt_a[4] = rnd[7:0];   // same address again, newer byte wins
		host_cmd(OP_WRITE, 16'd4, pkt_a[4], r);
		if (r != 16'd0) begin
			report_mismatch("rewrite status", int'(r), 0);
		end
		host_cmd(OP_WRITE_LEN, '0, '0, r);
		if (r != 16'd10) begin
			report_mismatch("build length", int'(r), 10);
		end
		host_cmd(OP_WRITE_NEXT, '0, '0, r);
		if (r != 16'd0) begin
			report_mismatch("commit status", int'(r), 0);
		end
		check_tx_frame(pkt_a, 10, "first");
		end_test("transmit frame");

		wait_tx_idle();
		host_cmd(OP_WRITE, 16'd64, 8'hA5, r);
		if (r != 16'd1) begin
			report_mismatch("write past packet end", int'(r), 1);
		end
		for (int i = 0; i < 5; i++) begin
			host_cmd(OP_WRITE_NEXT, '0, '0, r);
			if (r != ((i == 4) ? 16'd1 : 16'd0)) begin
				report_mismatch($sformatf("commit %0d status", i), int'(r), (i == 4) ? 1 : 0);
			end
		end
		random_payload(0, pkt_b);
		for (int i = 0; i < 4; i++) begin
			check_tx_frame(pkt_b, 0, "empty");
		end
		end_test("transmit ring full");

		random_payload(20, pkt_b);
		drive_rx(pkt_b, 20, 0);
		check_rx_packet(pkt_b, 20, "good rx");
		host_cmd(OP_READ_NEXT, '0, '0, r);
		if (r != 16'd1) begin
			report_mismatch("rx ring after release", int'(r), 1);
		end
		end_test("receive good frame");

		for (int f = 1; f <= 3; f++) begin
			drive_rx(pkt_b, 20, f);
			repeat (20) @(posedge clock);   // frame is judged as rx_dv falls
			#1;
			host_cmd(OP_READ_NEXT, '0, '0, r);
			if (r != 16'd1) begin
				report_mismatch($sformatf("rx ring after bad frame %0d", f), int'(r), 1);
			end
		end
		end_test("receive bad frames");

		wait_tx_idle();
		loopback = 1'b1;
		take_bits(5, rnd);
		len_a = 1 + int'(rnd[4:0]);
		random_payload(len_a, pkt_a);
		take_bits(5, rnd);
		len_b = 1 + int'(rnd[4:0]);
		random_payload(len_b, pkt_b);
		send_packet(pkt_a, len_a);
		send_packet(pkt_b, len_b);
		check_tx_frame(pkt_a, len_a, "loop a");
		check_tx_frame(pkt_b, len_b, "loop b");
		check_rx_packet(pkt_a, len_a, "loop a");
		check_rx_packet(pkt_b, len_b, "loop b");
		host_cmd(OP_READ_NEXT, '0, '0, r);
		if (r != 16'd1) begin
			report_mismatch("rx ring after loopback", int'(r), 1);
		end
		end_test("loopback");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			errors + mon_errors);
		if ((errors + mon_errors == 0) && (tests_failed == 0)) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
eth_host_pkg.sv
eth_frame_pkg.sv
eth_tx_path.sv
eth_rx_path.sv
eth_host_port.sv
eth_mac_top.sv
tb_eth_mac.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tb_eth_mac
FLIST      = flist.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing -j 0
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
